// ==== Makefile ====
TOP = tb_sram_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
mem_pkg.sv
mem_port_if.sv
sram_macro_32x256.sv
sram_banked_1rw1r.sv
sram_collision_bypass.sv
sram_subsystem.sv
tb_sram_subsystem.sv

// ==== mem_pkg.sv ====
package mem_pkg;

  // one data word and its byte lanes
  localparam int data_width = 32;
  localparam int mask_width = 4;
  localparam int byte_width = data_width / mask_width;

  // address split between the bank index and the word inside a macro
  localparam int bank_addr_width = 8;
  localparam int bank_depth = 2 ** bank_addr_width;
  localparam int num_banks = 4;
  localparam int bank_sel_width = 2;
  localparam int addr_width = bank_addr_width + bank_sel_width;

  typedef logic [data_width-1:0] word_t;

  typedef logic [addr_width-1:0] addr_t;

  // word address inside one macro
  typedef logic [bank_addr_width-1:0] bank_addr_t;

  // the upper address bits pick one of the macros
  typedef logic [bank_sel_width-1:0] bank_sel_t;

  // bit k enables bits 8k to 8k+7 of a word
  typedef logic [mask_width-1:0] wmask_t;

endpackage

// ==== mem_port_if.sv ====
interface mem_port_if;

  // active low chip select and write enable
  logic csb;
  logic web;

  mem_pkg::wmask_t wmask;
  mem_pkg::addr_t addr;
  mem_pkg::word_t din;

  // read data, valid the cycle after the read edge
  mem_pkg::word_t dout;

  modport requester (
    output csb,
    output web,
    output wmask,
    output addr,
    output din,
    input dout
  );

  modport memory (
    input csb,
    input web,
    input wmask,
    input addr,
    input din,
    output dout
  );

  // passive view for logic that only watches the port
  modport monitor (
    input csb,
    input web,
    input wmask,
    input addr,
    input din,
    input dout
  );

endinterface

// ==== sram_banked_1rw1r.sv ====
module sram_banked_1rw1r (
  input logic clk1,
  input logic rst,
  mem_port_if.memory p0,
  mem_port_if.memory p1
);

  mem_pkg::bank_sel_t bank0;
  mem_pkg::bank_sel_t bank1;
  mem_pkg::bank_addr_t word0;
  mem_pkg::bank_addr_t word1;

  // bank index of the last read on each port
  mem_pkg::bank_sel_t bank0_q;
  mem_pkg::bank_sel_t bank1_q;

  logic rd0;
  logic rd1;

  mem_pkg::word_t dout0_w [mem_pkg::num_banks];
  mem_pkg::word_t dout1_w [mem_pkg::num_banks];

  assign bank0 = p0.addr[mem_pkg::addr_width-1:mem_pkg::bank_addr_width];
  assign bank1 = p1.addr[mem_pkg::addr_width-1:mem_pkg::bank_addr_width];
  assign word0 = p0.addr[mem_pkg::bank_addr_width-1:0];
  assign word1 = p1.addr[mem_pkg::bank_addr_width-1:0];

  assign rd0 = !p0.csb && p0.web;
  assign rd1 = !p1.csb && p1.web;

  for (genvar i = 0; i < mem_pkg::num_banks; i++) begin : g_bank
    logic csb0_b;
    logic csb1_b;

    // only the addressed macro sees its chip select go low
    assign csb0_b = (bank0 == mem_pkg::bank_sel_t'(i)) ? p0.csb : 1'b1;
    assign csb1_b = (bank1 == mem_pkg::bank_sel_t'(i)) ? p1.csb : 1'b1;

    sram_macro_32x256 sram_macro_i (
      .clk1   (clk1),
      .csb0   (csb0_b),
      .web0   (p0.web),
      .wmask0 (p0.wmask),
      .addr0  (word0),
      .din0   (p0.din),
      .dout0  (dout0_w[i]),
      .csb1   (csb1_b),
      .addr1  (word1),
      .dout1  (dout1_w[i])
    );
  end

  // the index moves only with a read, so the mux keeps pointing at the
  // macro whose output register holds the last read word
  always_ff @(posedge clk1) begin
    if (rst) begin
      bank0_q <= '0;
    end else if (rd0) begin
      bank0_q <= bank0;
    end
  end

  always_ff @(posedge clk1) begin
    if (rst) begin
      bank1_q <= '0;
    end else if (rd1) begin
      bank1_q <= bank1;
    end
  end

  assign p0.dout = dout0_w[bank0_q];
  assign p1.dout = dout1_w[bank1_q];

endmodule

// ==== sram_collision_bypass.sv ====
module sram_collision_bypass (
  input logic clk1,
  input logic rst,

  // read-only port from the top level
  input logic csb1,
  input mem_pkg::addr_t addr1,
  output mem_pkg::word_t dout1,

  // port 0 traffic, watched for writes
  mem_port_if.monitor wr_mon,

  // port 1 toward the banked memory
  mem_port_if.requester mem
);

  logic rd1;
  logic wr0;
  logic hit;

  // state captured on a colliding edge
  logic coll_q;
  mem_pkg::word_t wdata_q;
  mem_pkg::wmask_t wmask_q;

  // the read-only port never writes
  assign mem.csb = csb1;
  assign mem.web = 1'b1;
  assign mem.wmask = '0;
  assign mem.addr = addr1;
  assign mem.din = '0;

  assign rd1 = !csb1;
  assign wr0 = !wr_mon.csb && !wr_mon.web;
  assign hit = rd1 && wr0 && (wr_mon.addr == addr1);

  // the flag follows each port 1 read and holds through idle cycles
  always_ff @(posedge clk1) begin
    if (rst) begin
      coll_q <= 1'b0;
    end else if (rd1) begin
      coll_q <= hit;
    end
  end

  always_ff @(posedge clk1) begin
    if (hit) begin
      wdata_q <= wr_mon.din;
      wmask_q <= wr_mon.wmask;
    end
  end

  // the macro returned the old word, so the written lanes are laid over it
  always_comb begin
    dout1 = mem.dout;
    if (coll_q) begin
      for (int k = 0; k < mem_pkg::mask_width; k++) begin
        if (wmask_q[k]) begin
          dout1[k*mem_pkg::byte_width +: mem_pkg::byte_width] =
            wdata_q[k*mem_pkg::byte_width +: mem_pkg::byte_width];
        end
      end
    end
  end

endmodule

// ==== sram_macro_32x256.sv ====
module sram_macro_32x256 (
  input logic clk1,

  // read/write port
  input logic csb0,
  input logic web0,
  input mem_pkg::wmask_t wmask0,
  input mem_pkg::bank_addr_t addr0,
  input mem_pkg::word_t din0,
  output mem_pkg::word_t dout0,

  // read-only port
  input logic csb1,
  input mem_pkg::bank_addr_t addr1,
  output mem_pkg::word_t dout1
);

  mem_pkg::word_t mem [mem_pkg::bank_depth];

  logic wr0;
  logic rd0;
  logic rd1;

  assign wr0 = !csb0 && !web0;
  assign rd0 = !csb0 && web0;
  assign rd1 = !csb1;

  // byte lanes are written independently under the mask
  always_ff @(posedge clk1) begin
    if (wr0) begin
      for (int k = 0; k < mem_pkg::mask_width; k++) begin
        if (wmask0[k]) begin
          mem[addr0][k*mem_pkg::byte_width +: mem_pkg::byte_width] <=
            din0[k*mem_pkg::byte_width +: mem_pkg::byte_width];
        end
      end
    end
  end

  // port 0 output register only loads on a read, a write leaves it alone
  always_ff @(posedge clk1) begin
    if (rd0) begin
      dout0 <= mem[addr0];
    end
  end

  // port 1 samples the array before this edge's write lands, so a
  // same word collision returns the old contents
  always_ff @(posedge clk1) begin
    if (rd1) begin
      dout1 <= mem[addr1];
    end
  end

endmodule

// ==== sram_subsystem.sv ====
module sram_subsystem (
  input logic clk1,
  input logic rst,

  // read/write port
  input logic csb0,
  input logic web0,
  input mem_pkg::wmask_t wmask0,
  input mem_pkg::addr_t addr0,
  input mem_pkg::word_t din0,
  output mem_pkg::word_t dout0,

  // read-only port
  input logic csb1,
  input mem_pkg::addr_t addr1,
  output mem_pkg::word_t dout1
);

  mem_port_if p0 ();
  mem_port_if p1 ();

  // port 0 goes from the pins straight to the memory
  assign p0.csb = csb0;
  assign p0.web = web0;
  assign p0.wmask = wmask0;
  assign p0.addr = addr0;
  assign p0.din = din0;
  assign dout0 = p0.dout;

  // port 1 passes through the bypass, which also watches port 0
  sram_collision_bypass sram_collision_bypass_i (
    .clk1   (clk1),
    .rst    (rst),
    .csb1   (csb1),
    .addr1  (addr1),
    .dout1  (dout1),
    .wr_mon (p0.monitor),
    .mem    (p1.requester)
  );

  sram_banked_1rw1r sram_banked_1rw1r_i (
    .clk1 (clk1),
    .rst  (rst),
    .p0   (p0.memory),
    .p1   (p1.memory)
  );

endmodule

// ==== tb_sram_subsystem.sv ====
module tb_sram_subsystem;

  localparam int mem_words = 2 ** mem_pkg::addr_width;
  localparam int part_count = 64;
  localparam int stim_cycles = 3 + 2 * mem_words + 2 * part_count + 128 + 2 * 32 + 4 * 16
    + 22 + 3;
  localparam int timeout_cycles = 2 * stim_cycles + 100;

  logic clk1;
  logic rst;
  logic csb0;
  logic web0;
  mem_pkg::wmask_t wmask0;
  mem_pkg::addr_t addr0;
  mem_pkg::word_t din0;
  mem_pkg::word_t dout0;
  logic csb1;
  mem_pkg::addr_t addr1;
  mem_pkg::word_t dout1;

  // reference contents and the value each dout should hold
  mem_pkg::word_t ref_mem [mem_words];
  mem_pkg::word_t exp0;
  mem_pkg::word_t exp1;
  logic valid0;
  logic valid1;
  int cycle_cnt;

  mem_pkg::addr_t part_addr [part_count];

  sram_subsystem sram_subsystem_i (
    .clk1   (clk1),
    .rst    (rst),
    .csb0   (csb0),
    .web0   (web0),
    .wmask0 (wmask0),
    .addr0  (addr0),
    .din0   (din0),
    .dout0  (dout0),
    .csb1   (csb1),
    .addr1  (addr1),
    .dout1  (dout1)
  );

  initial begin
    clk1 = 1'b0;
    forever #10 clk1 = ~clk1;
  end

  function automatic mem_pkg::word_t fill_pattern(input mem_pkg::addr_t a);
    return {6'h2a, a, 6'h15, ~a};
  endfunction

  // byte k of the result comes from the new word when mask bit k is set
  function automatic mem_pkg::word_t merge_bytes(input mem_pkg::word_t old_w,
                                                 input mem_pkg::word_t new_w,
                                                 input mem_pkg::wmask_t m);
    mem_pkg::word_t r;
    r = old_w;
    for (int k = 0; k < 4; k++) begin
      if (m[k]) begin
        r[8*k +: 8] = new_w[8*k +: 8];
      end
    end
    return r;
  endfunction

  task automatic drive_cycle(input logic c0, input logic w0, input mem_pkg::wmask_t m0,
                             input mem_pkg::addr_t a0, input mem_pkg::word_t d0,
                             input logic c1, input mem_pkg::addr_t a1);
    @(posedge clk1);
    csb0 <= c0;
    web0 <= w0;
    wmask0 <= m0;
    addr0 <= a0;
    din0 <= d0;
    csb1 <= c1;
    addr1 <= a1;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_cycle(1'b1, 1'b1, '0, '0, '0, 1'b1, '0);
    end
  endtask

  // the model sees the inputs that the DUT samples on this same edge
  always @(posedge clk1) begin
    if (rst) begin
      valid0 <= 1'b0;
      valid1 <= 1'b0;
    end else begin
      if (!csb1) begin
        if (!csb0 && !web0 && addr0 == addr1) begin
          exp1 <= merge_bytes(ref_mem[addr1], din0, wmask0);
        end else begin
          exp1 <= ref_mem[addr1];
        end
        valid1 <= 1'b1;
      end
      if (!csb0 && web0) begin
        exp0 <= ref_mem[addr0];
        valid0 <= 1'b1;
      end
      if (!csb0 && !web0) begin
        ref_mem[addr0] = merge_bytes(ref_mem[addr0], din0, wmask0);
      end
    end
  end

  // each dout must equal the last predicted read on its port on every cycle
  check_dout0: assert property (@(posedge clk1) disable iff (rst) valid0 |-> dout0 == exp0)
    else begin
      $display("FAILED dout0 got %h expected %h", $sampled(dout0), $sampled(exp0));
      $display("TEST FAILED");
      $fatal(1, "dout0 mismatch");
    end

  check_dout1: assert property (@(posedge clk1) disable iff (rst) valid1 |-> dout1 == exp1)
    else begin
      $display("FAILED dout1 got %h expected %h", $sampled(dout1), $sampled(exp1));
      $display("TEST FAILED");
      $fatal(1, "dout1 mismatch");
    end

  always @(posedge clk1) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: the stimulus did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int seed;
    mem_pkg::addr_t a;
    mem_pkg::addr_t b;
    seed = 23;
    void'($urandom(seed));
    cycle_cnt <= 0;
    rst <= 1'b1;
    csb0 <= 1'b1;
    web0 <= 1'b1;
    wmask0 <= '0;
    addr0 <= '0;
    din0 <= '0;
    csb1 <= 1'b1;
    addr1 <= '0;
    repeat (3) @(posedge clk1);
    rst <= 1'b0;

    // fill every bank with full words and read them back on port 0
    for (int i = 0; i < mem_words; i++) begin
      a = mem_pkg::addr_t'(i);
      drive_cycle(1'b0, 1'b0, 4'hf, a, fill_pattern(a), 1'b1, '0);
    end
    for (int i = 0; i < mem_words; i++) begin
      drive_cycle(1'b0, 1'b1, '0, mem_pkg::addr_t'(i), '0, 1'b1, '0);
    end

    // partial writes with random masks are read back on port 1
    for (int j = 0; j < part_count; j++) begin
      part_addr[j] = mem_pkg::addr_t'($urandom);
      drive_cycle(1'b0, 1'b0, mem_pkg::wmask_t'($urandom), part_addr[j],
                  mem_pkg::word_t'($urandom), 1'b1, '0);
    end
    for (int j = 0; j < part_count; j++) begin
      drive_cycle(1'b1, 1'b1, '0, '0, '0, 1'b0, part_addr[j]);
    end

    // both ports read every cycle and hop between banks
    for (int i = 0; i < 128; i++) begin
      a = {mem_pkg::bank_sel_t'(i), mem_pkg::bank_addr_t'($urandom)};
      b = {mem_pkg::bank_sel_t'(i + 1), mem_pkg::bank_addr_t'($urandom)};
      drive_cycle(1'b0, 1'b1, '0, a, '0, 1'b0, b);
    end

    // a colliding write and read are followed by a plain read on port 1
    for (int i = 0; i < 32; i++) begin
      a = mem_pkg::addr_t'($urandom);
      drive_cycle(1'b0, 1'b0, mem_pkg::wmask_t'($urandom), a, mem_pkg::word_t'($urandom),
                  1'b0, a);
      drive_cycle(1'b1, 1'b1, '0, '0, '0, 1'b0, a ^ 10'h201);
    end

    // writes on port 0 must leave dout0 at the last read word
    for (int i = 0; i < 16; i++) begin
      drive_cycle(1'b0, 1'b1, '0, mem_pkg::addr_t'($urandom), '0, 1'b1, '0);
      repeat (3) begin
        drive_cycle(1'b0, 1'b0, 4'hf, mem_pkg::addr_t'($urandom),
                    mem_pkg::word_t'($urandom), 1'b1, '0);
      end
    end

    // idle stretch between two reads of the same words
    a = mem_pkg::addr_t'($urandom);
    b = mem_pkg::addr_t'($urandom);
    drive_cycle(1'b0, 1'b1, '0, a, '0, 1'b0, b);
    idle_cycles(20);
    drive_cycle(1'b0, 1'b1, '0, a, '0, 1'b0, b);
    idle_cycles(3);

    $display("TEST OK");
    $finish;
  end

endmodule
